// File: hdl/icache_addr_pkg.sv
package icache_addr_pkg;

  // fetch address split: tag | index | offset
  localparam int ADDR_W     = 32;
  localparam int TAG_W      = 19;
  localparam int INDEX_W    = 7;
  localparam int OFFSET_W   = 6;
  localparam int WORD_SEL_W = 4;  // 16 words per line

  // 128 lines of 64 bytes
  localparam int LINES          = 128;
  localparam int WORDS_PER_LINE = 16;

  // top nibble of the uncached region
  localparam logic [3:0] UNCACHE_NIBBLE = 4'hA;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [TAG_W-1:0] tag_t;

  typedef logic [INDEX_W-1:0] index_t;

  // word within a line
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  typedef logic [31:0] word_t;  // one instruction

endpackage

// File: hdl/icache_mem_pkg.sv
package icache_mem_pkg;

  localparam int BURST_LEN_W = 8;

  typedef logic [BURST_LEN_W-1:0] burst_len_t;  // beats minus one

  // length codes for the memory read port
  localparam burst_len_t BURST_LINE   = 8'd15;  // full line refill
  localparam burst_len_t BURST_SINGLE = 8'd0;   // uncached word

  // controller states
  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } icache_state_t;

endpackage

// File: hdl/cache_line_if.sv
`timescale 1ns/1ps

interface cache_line_if import icache_addr_pkg::*; ();

  // shared line index, used by both stores
  index_t    rd_index;
  tag_t      cmp_tag;
  word_sel_t rd_word_sel;

  // refill side
  logic      wr_word_en;
  word_sel_t wr_word_sel;
  word_t     wr_word;
  logic      tag_wr_en;  // last refill beat

  // lookup results
  logic      hit;
  word_t     rd_word;

  modport ctrl (
    output rd_index, cmp_tag, rd_word_sel,
    output wr_word_en, wr_word_sel, wr_word, tag_wr_en,
    input  hit, rd_word
  );

  modport tag (input rd_index, cmp_tag, tag_wr_en, output hit);

  modport data (
    input  rd_index, rd_word_sel, wr_word_en, wr_word_sel, wr_word, tag_wr_en,
    output rd_word
  );

endinterface

// File: hdl/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store
  import icache_addr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  cache_line_if.tag  line
);

  logic [LINES-1:0] valid_q;  // one bit per line
  tag_t             tag_mem [LINES];

  tag_t stored_tag;
  logic stored_valid;

  assign stored_tag   = tag_mem[line.rd_index];
  assign stored_valid = valid_q[line.rd_index];

  // combinational compare, ready in the lookup cycle
  assign line.hit = stored_valid && (stored_tag == line.cmp_tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (line.tag_wr_en) begin
      valid_q[line.rd_index] <= 1'b1;
    end
  end

  // tag array itself
  always_ff @(posedge clk) begin
    if (line.tag_wr_en) begin
      tag_mem[line.rd_index] <= line.cmp_tag;
    end
  end

  // a refill ends once, then the controller goes back to idle
  a_tag_wr_single : assert property (
    @(posedge clk) disable iff (rst)
    line.tag_wr_en |=> !line.tag_wr_en
  );

endmodule

// File: hdl/icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store
  import icache_addr_pkg::*;
(
  input  logic        clk,
  cache_line_if.data  line
);

  localparam int DEPTH = LINES * WORDS_PER_LINE;

  word_t mem [DEPTH];  // 2048 words

  logic [INDEX_W+WORD_SEL_W-1:0] rd_addr;
  logic [INDEX_W+WORD_SEL_W-1:0] wr_addr;

  // same line index for read and refill
  assign rd_addr = {line.rd_index, line.rd_word_sel};
  assign wr_addr = {line.rd_index, line.wr_word_sel};

  // one refill beat per write
  always_ff @(posedge clk) begin
    if (line.wr_word_en) begin
      mem[wr_addr] <= line.wr_word;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    line.rd_word <= mem[rd_addr];
  end

  // tag goes valid together with the last word only
  a_tag_on_last_word : assert property (
    @(posedge clk)
    (line.wr_word_en && line.tag_wr_en) |-> (line.wr_word_sel == '1)
  );

endmodule

// File: hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
  import icache_addr_pkg::*;
  import icache_mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // fetch side
  input  addr_t       fetch_addr_i,
  input  logic        fetch_valid_i,
  output word_t       fetch_data_o,
  output logic        fetch_valid_o,

  // memory read port
  output addr_t       mem_araddr_o,
  output logic        mem_arvalid_o,
  output burst_len_t  mem_rlen_o,
  input  word_t       mem_rdata_i,
  input  logic        mem_rready_i,

  cache_line_if.ctrl  line
);

  icache_state_t state;

  addr_t     req_addr;  // captured request
  addr_t     rd_addr;
  word_sel_t beat_cnt;

  logic beat;
  logic uncached;
  logic last_beat;
  logic take_req;

  assign beat      = mem_arvalid_o && mem_rready_i;
  assign last_beat = burst_len_t'(beat_cnt) == mem_rlen_o;

  // the response cycle consumes the held request
  assign take_req = fetch_valid_i && !fetch_valid_o;

  assign uncached = req_addr[ADDR_W-1 -: 4] == UNCACHE_NIBBLE;

  // idle reads ahead from the incoming address so the word is ready in lookup
  assign rd_addr = (state == ST_IDLE) ? fetch_addr_i : req_addr;

  assign line.rd_index    = rd_addr[OFFSET_W +: INDEX_W];
  assign line.rd_word_sel = rd_addr[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
  assign line.cmp_tag     = req_addr[ADDR_W-1 -: TAG_W];

  // refill writes straight from the read data
  assign line.wr_word_en  = (state == ST_REFILL) && beat;
  assign line.wr_word_sel = beat_cnt;
  assign line.wr_word     = mem_rdata_i;
  assign line.tag_wr_en   = line.wr_word_en && last_beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= ST_RESET;
      mem_arvalid_o <= 1'b0;
      fetch_valid_o <= 1'b0;
      beat_cnt      <= '0;
    end else begin
      fetch_valid_o <= 1'b0;  // single cycle pulse
      case (state)
        ST_RESET: state <= ST_IDLE;
        ST_IDLE: begin
          if (take_req) begin
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (uncached) begin
            mem_arvalid_o <= 1'b1;
            state         <= ST_UNCACHED;
          end else if (line.hit) begin
            fetch_valid_o <= 1'b1;
            state         <= ST_IDLE;
          end else begin
            mem_arvalid_o <= 1'b1;
            beat_cnt      <= '0;
            state         <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              // no response here, the fetch unit re-issues and hits
              mem_arvalid_o <= 1'b0;
              state         <= ST_IDLE;
            end
          end
        end
        ST_UNCACHED: begin
          if (beat) begin
            mem_arvalid_o <= 1'b0;
            fetch_valid_o <= 1'b1;
            state         <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request, burst setup and response word
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && take_req) begin
      req_addr <= fetch_addr_i;
    end
    if (state == ST_LOOKUP) begin
      if (uncached) begin
        mem_araddr_o <= req_addr;  // exact word
        mem_rlen_o   <= BURST_SINGLE;
      end else begin
        mem_araddr_o <= {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        mem_rlen_o   <= BURST_LINE;
      end
      fetch_data_o <= line.rd_word;
    end
    if (state == ST_UNCACHED && beat) begin
      fetch_data_o <= mem_rdata_i;
    end
  end

  a_no_req_in_idle : assert property (
    @(posedge clk) disable iff (rst)
    (state == ST_IDLE) |-> !mem_arvalid_o
  );

  // burst stays within its declared length
  a_beat_in_range : assert property (
    @(posedge clk) disable iff (rst)
    mem_arvalid_o |-> (burst_len_t'(beat_cnt) <= mem_rlen_o)
  );

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_addr_pkg::*;
  import icache_mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // fetch unit
  input  addr_t       fetch_addr_i,
  input  logic        fetch_valid_i,
  output word_t       fetch_data_o,
  output logic        fetch_valid_o,

  // memory read port
  output addr_t       mem_araddr_o,
  output logic        mem_arvalid_o,
  output burst_len_t  mem_rlen_o,
  input  word_t       mem_rdata_i,
  input  logic        mem_rready_i
);

  cache_line_if line_if ();

  icache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_o  (fetch_data_o),
    .fetch_valid_o (fetch_valid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rlen_o    (mem_rlen_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rready_i  (mem_rready_i),
    .line          (line_if.ctrl)
  );

  // both stores see the same line index
  icache_tag_store u_tag_store (
    .clk  (clk),
    .rst  (rst),
    .line (line_if.tag)
  );

  icache_data_store u_data_store (
    .clk  (clk),
    .line (line_if.data)
  );

endmodule

// File: verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
  import icache_addr_pkg::*;
  import icache_mem_pkg::*;
();

  localparam int N_DIRECTED     = 8;
  localparam int N_RANDOM       = 400;
  localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 80;
  localparam int HIT_LATENCY    = 2;  // edges from drive to response

  logic       clk;
  logic       rst;
  addr_t      fetch_addr_i;
  logic       fetch_valid_i;
  word_t      fetch_data_o;
  logic       fetch_valid_o;
  addr_t      mem_araddr_o;
  logic       mem_arvalid_o;
  burst_len_t mem_rlen_o;
  word_t      mem_rdata_i;
  logic       mem_rready_i;

  logic [31:0] addr_rng  = 32'h533;
  logic [31:0] stall_rng = 32'h533;
  int          cycle_cnt = 0;

  // line state the cache should have
  logic model_valid [LINES];
  tag_t model_tag   [LINES];

  // bursts seen by the memory model, oldest first
  addr_t      burst_addr_q [$];
  burst_len_t burst_len_q  [$];

  logic       arvalid_q = 1'b0;
  int         beat_idx  = 0;
  addr_t      cur_addr;
  burst_len_t cur_len;

  icache_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_o  (fetch_data_o),
    .fetch_valid_o (fetch_valid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rlen_o    (mem_rlen_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rready_i  (mem_rready_i)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory holds the inverted word address
  function automatic word_t mem_word(input addr_t a);
    return ~{a[31:2], 2'b00};
  endfunction

  // few tags, so lines get evicted often
  function automatic tag_t pick_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 19'h00010;
      2'd1:    return 19'h0A5A5;
      2'd2:    return 19'h3C3C3;
      default: return 19'h12345;
    endcase
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
    end
  endtask

  task automatic check_len(input burst_len_t got, input burst_len_t exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                                $time, what, got, exp));
    end
  endtask

  // one fetch, held until the response pulse
  task automatic run_request(input addr_t addr);
    tag_t       tag;
    index_t     idx;
    logic       uncached;
    logic       hit;
    int         waited;
    addr_t      exp_addr;
    burst_len_t exp_len;
    tag      = addr[ADDR_W-1 -: TAG_W];
    idx      = addr[OFFSET_W +: INDEX_W];
    uncached = addr[ADDR_W-1 -: 4] == UNCACHE_NIBBLE;
    hit      = !uncached && model_valid[idx] && (model_tag[idx] == tag);
    fetch_addr_i  = addr;
    fetch_valid_i = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      #2;
      waited++;
    end while (!fetch_valid_o);
    fetch_valid_i = 1'b0;
    check_word(fetch_data_o, mem_word(addr), $sformatf("fetch_data_o for %h", addr));
    if (hit) begin
      if (burst_addr_q.size() != 0) begin
        stop_with_error($sformatf("memory was read for %h, which should have hit", addr));
      end
      if (waited != HIT_LATENCY) begin
        stop_with_error($sformatf("hit on %h answered after %0d cycles instead of %0d",
                                  addr, waited, HIT_LATENCY));
      end
    end else begin
      if (burst_addr_q.size() != 1) begin
        stop_with_error($sformatf("expected one memory read for %h but saw %0d",
                                  addr, burst_addr_q.size()));
      end
      exp_addr = uncached ? addr : {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      exp_len  = uncached ? BURST_SINGLE : BURST_LINE;
      check_addr(burst_addr_q.pop_front(), exp_addr, "mem_araddr_o");
      check_len(burst_len_q.pop_front(), exp_len, "mem_rlen_o");
      if (!uncached) begin
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
      end
    end
    @(posedge clk);
    #2;
    check_flag(fetch_valid_o, 1'b0, "fetch_valid_o after response");
  endtask

  // memory model, one beat per edge with rready high
  always @(posedge clk) begin
    #2;
    if (arvalid_q && mem_rready_i) beat_idx++;
    if (mem_arvalid_o) begin
      if (!arvalid_q) begin  // new burst
        cur_addr = mem_araddr_o;
        cur_len  = mem_rlen_o;
        beat_idx = 0;
        burst_addr_q.push_back(mem_araddr_o);
        burst_len_q.push_back(mem_rlen_o);
      end
      check_addr(mem_araddr_o, cur_addr, "mem_araddr_o during burst");
      check_len(mem_rlen_o, cur_len, "mem_rlen_o during burst");
      if (beat_idx > int'(mem_rlen_o)) begin
        stop_with_error("the memory read ran past its burst length");
      end
      mem_rdata_i = mem_word(cur_addr + addr_t'(beat_idx * 4));
    end else begin
      beat_idx    = 0;
      mem_rdata_i = '0;
    end
    arvalid_q = mem_arvalid_o;
    stall_rng = lcg_next(stall_rng);
    mem_rready_i = stall_rng[31:30] != 2'b00;  // low about one cycle in four
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("the run hung and did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
    end
  end

  initial begin
    addr_t line_a;
    addr_t line_b;
    addr_t addr;
    rst           = 1'b1;
    fetch_addr_i  = '0;
    fetch_valid_i = 1'b0;
    mem_rdata_i   = '0;
    mem_rready_i  = 1'b0;
    for (int i = 0; i < LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      #2;
      if (i == 7) rst = 1'b0;  // 8 cycles of reset
      check_flag(fetch_valid_o, 1'b0, "fetch_valid_o around reset");
      check_flag(mem_arvalid_o, 1'b0, "mem_arvalid_o around reset");
    end

    // directed: cold miss, hits, uncached twice, conflict on one index
    line_a = {pick_tag(2'd0), 7'h10, 4'h5, 2'b00};
    line_b = {pick_tag(2'd1), 7'h10, 4'h2, 2'b00};
    run_request(line_a);
    run_request(line_a);
    run_request({line_a[31:6], 4'hC, 2'b00});
    run_request(32'hA000_0044);
    run_request(32'hA000_0044);
    run_request(line_b);
    run_request(line_a);
    run_request(line_a);

    for (int n = 0; n < N_RANDOM; n++) begin
      addr_rng = lcg_next(addr_rng);
      if (addr_rng[31:29] == 3'd0) begin
        addr = {UNCACHE_NIBBLE, 20'h00100, addr_rng[26:21], 2'b00};
      end else begin
        addr = {pick_tag(addr_rng[28:27]), {4'b0101, addr_rng[26:24]}, addr_rng[23:20], 2'b00};
      end
      run_request(addr);
    end

    $display("Everything OK");
    $finish;
  end

endmodule

// File: all.f
hdl/icache_addr_pkg.sv
hdl/icache_mem_pkg.sv
hdl/cache_line_if.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - hdl/icache_addr_pkg.sv
  - hdl/icache_mem_pkg.sv
  - hdl/cache_line_if.sv
  - hdl/icache_tag_store.sv
  - hdl/icache_data_store.sv
  - hdl/icache_ctrl.sv
  - hdl/icache_top.sv
  - target: test
    files:
      - verif/icache_tb.sv
